//--- verilog.f
+incdir+logic
logic/riscv_pkg.sv
logic/pc_control.sv
logic/decoder.sv
logic/register_file.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/riscv_pipeline.sv
testbench/riscv_pipeline_properties.sv
testbench/riscv_pipeline_tb.sv

//--- Makefile
TOP = riscv_pipeline_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- testbench/riscv_pipeline_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defs.svh"

module riscv_pipeline_tb
    import riscv_pkg::*;
();

    localparam logic [31:0] NOP      = 32'h0000_0013;
    localparam logic [31:0] END_ADDR = 32'h0000_03fc;
    // Roughly 350 program words over five runs, each with reset and drain.
    localparam int CYCLE_LIMIT = 2 * (350 + 5 * 24);

    logic clk = 1'b0;
    logic rst = 1'b1;
    instr_t instruction;
    logic [`XLEN-1:0] read_data, pc, data_addr, write_data, alu_result, write_back_data;
    logic mem_read, mem_write;

    logic [31:0] imem [512];
    logic [31:0] dmem [256];
    logic [31:0] exp_addr[$], exp_data[$], got_addr[$], got_data[$];
    logic [`XLEN-1:0] load_addr = '0;
    int n_words, store_slot, errors = 0, checks = 0, cycles = 0;
    int seed = 32'h2e40;
    logic done = 1'b0;

    // Cycle-exact probe on one producer word.
    logic [31:0] probe_word = '0;
    logic [31:0] probe_alu, probe_wb;
    logic [2:0]  probe_stage = '0;
    int          probe_hits = 0;

    riscv_pipeline DUT (
        .clk             (clk),
        .rst             (rst),
        .instruction     (instruction),
        .read_data       (read_data),
        .pc              (pc),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .data_addr       (data_addr),
        .write_data      (write_data),
        .alu_result      (alu_result),
        .write_back_data (write_back_data)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Memory models.
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] fetch(input logic [31:0] addr);
        logic [31:0] offset;
        offset = addr - `INITIAL_PC;
        if (offset[31:11] != '0) begin
            return NOP;
        end
        return imem[offset[10:2]];
    endfunction

    // One cycle of read latency on the instruction side.
    always @(posedge clk) begin
        instruction <= fetch(pc);
    end

    // Load data answers in write-back from the address of the memory stage.
    always @(posedge clk) begin
        load_addr <= data_addr;
    end

    assign read_data = dmem[load_addr[9:2]];

    always @(posedge clk) begin
        if (mem_write) begin
            dmem[data_addr[9:2]] <= write_data;
            if (data_addr == END_ADDR) begin
                done <= 1'b1;
            end else begin
                got_addr.push_back(data_addr);
                got_data.push_back(write_data);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout: the program did not reach its end store in time.");
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Result one cycle after decode, write-back value three cycles after.
    always @(negedge clk) begin
        probe_stage <= {probe_stage[1:0], instruction === probe_word};
        if (probe_stage[0]) begin
            check(alu_result, probe_alu, "alu_result");
        end
        if (probe_stage[2]) begin
            probe_hits++;
            check(write_back_data, probe_wb, "write_back_data");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Encoders and reference rules.
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] r_type(input logic [2:0] f3, input logic alt,
                                           input logic [4:0] rd, rs1, rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rs1, rs2);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a, b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Program building and running.
    ////////////////////////////////////////////////////////////////////////////

    task automatic check(input logic [31:0] got, input logic [31:0] expected, input string what);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic emit(input logic [31:0] word);
        imem[n_words] = word;
        n_words++;
    endtask

    task automatic gap();
        repeat (3) emit(NOP);
    endtask

    // Word 0 runs twice after reset, so it is always a NOP.
    task automatic new_program();
        for (int i = 0; i < 512; i++) imem[i] = NOP;
        for (int i = 0; i < 256; i++) dmem[i] = 32'ha500_0000 ^ (i * 32'h0001_0101);
        exp_addr.delete();
        exp_data.delete();
        probe_word = '0;
        probe_hits = 0;
        n_words = 0;
        store_slot = 0;
        emit(NOP);
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // Store rs2 to the next free result slot.
    task automatic store_result(input logic [4:0] rs2, input logic [31:0] value);
        emit(s_type(12'(32'h100 + 4 * store_slot), rs2, 5'd0));
        expect_store(32'h100 + 4 * store_slot, value);
        store_slot++;
    endtask

    task automatic run_program();
        gap();
        emit(s_type(END_ADDR[11:0], 5'd0, 5'd0));
        @(posedge clk);
        rst <= 1'b1;
        done <= 1'b0;
        for (int k = 0; k < 8; k++) begin
            @(negedge clk);
            if (k > 0) begin
                check(pc, `INITIAL_PC, "pc in reset");
                check(32'(mem_read | mem_write), 32'd0, "memory strobe in reset");
            end
        end
        @(posedge clk);
        rst <= 1'b0;
        got_addr.delete();
        got_data.delete();
        for (int k = 0; k < 3; k++) begin
            @(negedge clk);
            check(pc, `INITIAL_PC + 4 * k, "pc after reset");
            if (k == 0) check(32'(mem_read | mem_write), 32'd0, "strobe after reset");
        end
        while (!done) @(posedge clk);
        check(32'(got_addr.size()), 32'(exp_addr.size()), "store count");
        for (int i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
            check(got_addr[i], exp_addr[i], "data_addr");
            check(got_data[i], exp_data[i], "write_data");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests.
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_test();
        new_program();
        run_program();
    endtask

    task automatic alu_test();
        logic [31:0] a, b, b_imm;
        logic [11:0] imm;
        a = $random(seed);
        b = $random(seed);
        new_program();
        dmem[0] = a;
        dmem[1] = b;
        emit(i_type(12'd0, 5'd0, 3'b010, 5'd1, 7'b0000011));
        emit(i_type(12'd4, 5'd0, 3'b010, 5'd2, 7'b0000011));
        gap();
        for (int f = 0; f < 8; f++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 0 || f == 0 || f == 5) begin
                    emit(r_type(3'(f), 1'(alt), 5'd3, 5'd1, 5'd2));
                    gap();
                    store_result(5'd3, alu_ref(3'(f), 1'(alt), a, b));
                end
                if (alt == 0 || f == 5) begin
                    imm = 12'($random(seed));
                    // Shifts carry funct7 in the upper immediate bits.
                    if (f == 1 || f == 5) imm = {1'b0, 1'(alt), 5'b0, imm[4:0]};
                    b_imm = {{20{imm[11]}}, imm};
                    emit(i_type(imm, 5'd1, 3'(f), 5'd3, 7'b0010011));
                    gap();
                    store_result(5'd3, alu_ref(3'(f), 1'(alt), a, b_imm));
                end
            end
        end
        run_program();
    endtask

    task automatic load_store_test();
        logic [31:0] w1, w2;
        w1 = $random(seed);
        w2 = $random(seed);
        new_program();
        dmem[32'h1f8 >> 2] = w1;
        dmem[32'h208 >> 2] = w2;
        // The first load is followed through execute and write-back.
        probe_word = i_type(-12'sd8, 5'd5, 3'b010, 5'd6, 7'b0000011);
        probe_alu  = 32'h1f8;
        probe_wb   = w1;
        emit(i_type(12'h200, 5'd0, 3'b000, 5'd5, 7'b0010011));
        gap();
        emit(probe_word);
        emit(i_type(12'd8, 5'd5, 3'b010, 5'd7, 7'b0000011));
        gap();
        emit(s_type(12'd16, 5'd6, 5'd5));
        expect_store(32'h210, w1);
        emit(s_type(-12'sd16, 5'd7, 5'd5));
        expect_store(32'h1f0, w2);
        run_program();
        check(32'(probe_hits), 32'd1, "probed load count");
    endtask

    task automatic branch_test();
        logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        int pair_a [3] = '{5, -3, 4};
        int pair_b [3] = '{5, 4, -3};
        int id;
        id = 0;
        new_program();
        for (int f = 0; f < 6; f++) begin
            for (int p = 0; p < 3; p++) begin
                emit(i_type(12'(pair_a[p]), 5'd0, 3'b000, 5'd1, 7'b0010011));
                emit(i_type(12'(pair_b[p]), 5'd0, 3'b000, 5'd2, 7'b0010011));
                emit(i_type(12'(id + 1), 5'd0, 3'b000, 5'd3, 7'b0010011));
                gap();
                // Target is the word after the marker store.
                emit(b_type(13'd20, br_f3[f], 5'd1, 5'd2));
                gap();
                emit(s_type(12'(32'h300 + 4 * id), 5'd3, 5'd0));
                if (!branch_ref(br_f3[f], 32'(pair_a[p]), 32'(pair_b[p]))) begin
                    expect_store(32'h300 + 4 * id, 32'(id + 1));
                end
                emit(s_type(12'(32'h380 + 4 * id), 5'd3, 5'd0));
                expect_store(32'h380 + 4 * id, 32'(id + 1));
                id++;
            end
        end
        run_program();
    endtask

    task automatic x0_and_bypass_test();
        logic [11:0] imm;
        imm = 12'($random(seed));
        new_program();
        emit(i_type(12'd123, 5'd0, 3'b000, 5'd0, 7'b0010011));
        gap();
        store_result(5'd0, 32'd0);
        // Consumer decoded in the write-back cycle of its producer.
        emit(i_type(imm, 5'd0, 3'b000, 5'd4, 7'b0010011));
        emit(NOP);
        emit(NOP);
        store_result(5'd4, {{20{imm[11]}}, imm});
        run_program();
    endtask

    initial begin
        instruction = NOP;
        reset_test();
        alu_test();
        load_store_test();
        branch_test();
        x0_and_bypass_test();
        $display("Errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/riscv_pipeline_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defs.svh"

module riscv_pipeline_properties
    import riscv_pkg::*;
(
    input wire logic             clk,
    input wire logic             rst,
    input wire logic [`XLEN-1:0] pc,
    input wire logic             mem_read,
    input wire logic             mem_write,
    input wire ex_mem_t          exmem
);

    // A word is either loaded or stored, never both.
    strobe_exclusive: assert property (@(posedge clk) !(mem_read && mem_write))
        else $error("mem_read and mem_write are high together");

    // Memory strobes stay quiet in the first cycle out of reset.
    strobe_quiet_after_reset: assert property (@(posedge clk)
        ($past(rst) && !rst) |-> (!mem_read && !mem_write))
        else $error("memory strobe high in the cycle after reset");

    // Sequential fetch unless the memory stage redirected it.
    pc_step_or_branch: assert property (@(posedge clk) disable iff (rst)
        $past(rst) || (pc == $past(pc) + `PC_STEP) || (pc == $past(exmem.branch_target)))
        else $error("pc moved by neither a step nor a branch target");

endmodule

bind riscv_pipeline riscv_pipeline_properties u_properties (
    .clk       (clk),
    .rst       (rst),
    .pc        (pc),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .exmem     (exmem)
);

`default_nettype wire

//--- logic/riscv_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defs.svh"

module riscv_pipeline
    import riscv_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire instr_t           instruction,
    input  wire logic [`XLEN-1:0] read_data,
    output logic [`XLEN-1:0]      pc,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic [`XLEN-1:0]      data_addr,
    output logic [`XLEN-1:0]      write_data,
    output logic [`XLEN-1:0]      alu_result,
    output logic [`XLEN-1:0]      write_back_data
);

    logic [`XLEN-1:0] id_pc;
    ctrl_t            id_ctrl;
    logic [`XLEN-1:0] id_imm;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    ex_mem_t          exmem;
    wb_req_t          wb;

    // Fetch and branch resolution.
    pc_control u_pc_control (
        .clk   (clk),
        .rst   (rst),
        .exmem (exmem),
        .pc    (pc),
        .id_pc (id_pc)
    );

    // Decode and register read work on the same word.
    decoder u_decoder (
        .instr (instruction),
        .ctrl  (id_ctrl),
        .imm   (id_imm)
    );

    register_file u_register_file (
        .clk      (clk),
        .rs1      (instruction.rs1),
        .rs2      (instruction.rs2),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    execute_stage u_execute_stage (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (id_ctrl),
        .imm        (id_imm),
        .id_pc      (id_pc),
        .instr      (instruction),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .exmem      (exmem),
        .alu_result (alu_result)
    );

    writeback_stage u_writeback_stage (
        .clk             (clk),
        .rst             (rst),
        .exmem           (exmem),
        .read_data       (read_data),
        .wb              (wb),
        .write_back_data (write_back_data)
    );

    // Data memory port, memory stage.
    assign mem_read   = exmem.ctrl.mem_read;
    assign mem_write  = exmem.ctrl.mem_write;
    assign data_addr  = exmem.alu_result;
    assign write_data = exmem.store_data;

endmodule

`default_nettype wire

//--- logic/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defs.svh"

module writeback_stage
    import riscv_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire ex_mem_t          exmem,
    input  wire logic [`XLEN-1:0] read_data,
    output wb_req_t               wb,
    output logic [`XLEN-1:0]      write_back_data
);

    mem_wb_t memwb;

    // MEM/WB register.
    always_ff @(posedge clk) begin
        if (rst) begin
            memwb <= '0;
        end else begin
            memwb <= '{reg_write:  exmem.ctrl.reg_write,
                       mem_to_reg: exmem.ctrl.mem_to_reg,
                       rd:         exmem.rd,
                       alu_result: exmem.alu_result};
        end
    end

    // Load data comes straight from data memory in this cycle.
    assign write_back_data = memwb.mem_to_reg ? read_data : memwb.alu_result;

    assign wb = '{we: memwb.reg_write, rd: memwb.rd, data: write_back_data};

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defs.svh"

module execute_stage
    import riscv_pkg::*;
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire ctrl_t            ctrl,
    input  wire logic [`XLEN-1:0] imm,
    input  wire logic [`XLEN-1:0] id_pc,
    input  wire instr_t           instr,
    input  wire logic [`XLEN-1:0] rs1_data,
    input  wire logic [`XLEN-1:0] rs2_data,
    output ex_mem_t               exmem,
    output logic [`XLEN-1:0]      alu_result
);

    id_ex_t                  idex;
    logic [`XLEN-1:0]        op_b;
    logic [`SHAMT_BITS-1:0]  shamt;
    logic [`XLEN-1:0]        target;
    logic                    zero;

    ////////////////////////////////////////////////////////////////////////////
    // ID/EX register.
    ////////////////////////////////////////////////////////////////////////////

    // Operands arrive already registered from the register file.
    always_ff @(posedge clk) begin
        if (rst) begin
            idex <= '0;
        end else begin
            idex <= '{ctrl: ctrl, imm: imm, pc: id_pc, funct3: instr.funct3, rd: instr.rd};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // ALU and branch target.
    ////////////////////////////////////////////////////////////////////////////

    assign op_b  = idex.ctrl.use_imm ? idex.imm : rs2_data;
    assign shamt = op_b[`SHAMT_BITS-1:0];

    always_comb begin
        case (idex.ctrl.alu_op)
            ALU_ADD:  alu_result = rs1_data + op_b;
            ALU_SUB:  alu_result = rs1_data - op_b;
            ALU_SLT:  alu_result = {{(`XLEN-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
            ALU_SLTU: alu_result = {{(`XLEN-1){1'b0}}, rs1_data < op_b};
            ALU_XOR:  alu_result = rs1_data ^ op_b;
            ALU_OR:   alu_result = rs1_data | op_b;
            ALU_AND:  alu_result = rs1_data & op_b;
            ALU_SLL:  alu_result = rs1_data << shamt;
            ALU_SRL:  alu_result = rs1_data >> shamt;
            ALU_SRA:  alu_result = $signed(rs1_data) >>> shamt;
            default:  alu_result = '0;
        endcase
    end

    assign zero   = (alu_result == '0);
    assign target = idex.imm + idex.pc;

    ////////////////////////////////////////////////////////////////////////////
    // EX/MEM register.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            exmem <= '0;
        end else begin
            exmem <= '{ctrl:          idex.ctrl,
                       funct3:        idex.funct3,
                       rd:            idex.rd,
                       alu_result:    alu_result,
                       zero:          zero,
                       branch_target: target,
                       store_data:    rs2_data};
        end
    end

endmodule

`default_nettype wire

//--- logic/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defs.svh"

module register_file
    import riscv_pkg::*;
(
    input  wire logic        clk,
    input  wire reg_addr_t   rs1,
    input  wire reg_addr_t   rs2,
    input  wire wb_req_t     wb,
    output logic [`XLEN-1:0] rs1_data,
    output logic [`XLEN-1:0] rs2_data
);

    logic [`XLEN-1:0] regs [`REG_COUNT] = '{default: '0};
    logic             wr_en;

    // x0 stays zero.
    assign wr_en = wb.we && (wb.rd != '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Registered reads.
    // A write in the same cycle to the same index passes straight through.
    always_ff @(posedge clk) begin
        if (wr_en && (rs1 == wb.rd)) begin
            rs1_data <= wb.data;
        end else begin
            rs1_data <= regs[rs1];
        end
        if (wr_en && (rs2 == wb.rd)) begin
            rs2_data <= wb.data;
        end else begin
            rs2_data <= regs[rs2];
        end
    end

endmodule

`default_nettype wire

//--- logic/decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defs.svh"

module decoder
    import riscv_pkg::*;
(
    input  wire instr_t      instr,
    output ctrl_t            ctrl,
    output logic [`XLEN-1:0] imm
);

    // Funct7 bit 5 selects sub and sra. Only register ops use it for sub.
    function automatic alu_op_e alu_select(
        input logic [2:0] funct3,
        input logic       alt,
        input logic       is_reg
    );
        case (funct3)
            F3_ADD:  return (alt && is_reg) ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SRL:  return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Control decode.
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl = '0;
        case (instr.opcode)
            OP: begin
                ctrl.alu_op    = alu_select(instr.funct3, instr.funct7[5], 1'b1);
                ctrl.reg_write = 1'b1;
            end
            OP_IMM: begin
                // Shift amount sits in the low immediate bits.
                ctrl.alu_op    = alu_select(instr.funct3, instr.funct7[5], 1'b0);
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            LOAD: begin
                ctrl.alu_op     = ALU_ADD;
                ctrl.use_imm    = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            STORE: begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            BRANCH: begin
                ctrl.branch = 1'b1;
                case (instr.funct3)
                    F3_BEQ, F3_BNE:   ctrl.alu_op = ALU_SUB;
                    F3_BLT, F3_BGE:   ctrl.alu_op = ALU_SLT;
                    F3_BLTU, F3_BGEU: ctrl.alu_op = ALU_SLTU;
                    default:          ctrl.alu_op = ALU_ADD;
                endcase
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Immediate generation.
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (instr.opcode)
            STORE: begin
                imm = {{(`XLEN-12){instr.funct7[6]}}, instr.funct7, instr.rd};
            end
            BRANCH: begin
                imm = {{(`XLEN-13){instr.funct7[6]}}, instr.funct7[6], instr.rd[0],
                       instr.funct7[5:0], instr.rd[4:1], 1'b0};
            end
            // I-type, also for R-type where it goes unused.
            default: begin
                imm = {{(`XLEN-12){instr.funct7[6]}}, instr.funct7, instr.rs2};
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/pc_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_defs.svh"

module pc_control
    import riscv_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire ex_mem_t     exmem,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] id_pc
);

    logic taken;

    // Branch decision in the memory stage.
    // Bit 0 of the result holds the slt or sltu outcome.
    always_comb begin
        taken = 1'b0;
        if (exmem.ctrl.branch) begin
            case (exmem.funct3)
                F3_BEQ:  taken = exmem.zero;
                F3_BNE:  taken = ~exmem.zero;
                F3_BLT:  taken = exmem.alu_result[0];
                F3_BLTU: taken = exmem.alu_result[0];
                F3_BGE:  taken = ~exmem.alu_result[0];
                F3_BGEU: taken = ~exmem.alu_result[0];
                default: taken = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `INITIAL_PC;
        end else if (taken) begin
            pc <= exmem.branch_target;
        end else begin
            pc <= pc + `PC_STEP;
        end
    end

    // Fetch address of the word now in decode.
    always_ff @(posedge clk) begin
        id_pc <= pc;
    end

endmodule

`default_nettype wire

//--- logic/riscv_pkg.sv
`default_nettype none

`include "riscv_defs.svh"

package riscv_pkg;

    typedef logic [4:0] reg_addr_t;

    // Major opcodes handled by the core.
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011
    } opcode_e;

    // Register and immediate ALU function codes.
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SRL  = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_e;

    // Conditional branch function codes.
    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } branch_funct3_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction word and stage payloads.
    ////////////////////////////////////////////////////////////////////////////

    // R-type field layout. Other formats are sliced from it.
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        opcode_e    opcode;
    } instr_t;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    branch;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    mem_to_reg;
    } ctrl_t;

    typedef struct packed {
        ctrl_t             ctrl;
        logic [`XLEN-1:0]  imm;
        logic [`XLEN-1:0]  pc;
        logic [2:0]        funct3;
        reg_addr_t         rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t             ctrl;
        logic [2:0]        funct3;
        reg_addr_t         rd;
        logic [`XLEN-1:0]  alu_result;
        logic              zero;
        logic [`XLEN-1:0]  branch_target;
        logic [`XLEN-1:0]  store_data;
    } ex_mem_t;

    typedef struct packed {
        logic              reg_write;
        logic              mem_to_reg;
        reg_addr_t         rd;
        logic [`XLEN-1:0]  alu_result;
    } mem_wb_t;

    // Register file write request.
    typedef struct packed {
        logic              we;
        reg_addr_t         rd;
        logic [`XLEN-1:0]  data;
    } wb_req_t;

endpackage

`default_nettype wire

//--- logic/riscv_defs.svh
`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

// Data path and address width.
`define XLEN 32

// Architectural integer registers, x0 included.
`define REG_COUNT 32

// First fetch address after reset.
`define INITIAL_PC 32'h0040_0000

// Sequential fetch increment in bytes.
`define PC_STEP 32'd4

// Shift amount field width for RV32.
`define SHAMT_BITS 5

`endif
